/* eeprom_ctrl_top.f */
logic/eeprom_pkg.sv
logic/cmd_fifo.sv
logic/wb_cmd_port.sv
logic/i2c_eeprom_master.sv
logic/eeprom_ctrl_top.sv
tb/eeprom_model.sv
tb/result_checker.sv
tb/eeprom_ctrl_asserts.sv
tb/tb_eeprom_ctrl.sv

/* logic/cmd_fifo.sv */
`timescale 1ns/1ns
module cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                push,
    input  eeprom_pkg::ee_cmd_t push_data,
    input  logic                pop,
    output eeprom_pkg::ee_cmd_t pop_data,
    output logic                full,
    output logic                empty
);
    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    eeprom_pkg::ee_cmd_t mem [FIFO_DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [CW-1:0]       count;
    logic                do_push;
    logic                do_pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + AW'(1);   // depth need not be 2^n
    endfunction

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign full     = (count == CW'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];   // oldest word, fall-through

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

/* logic/eeprom_ctrl_top.sv */
`timescale 1ns/1ns
module eeprom_ctrl_top #(
    parameter int FIFO_DEPTH  = 4,
    parameter int SCL_QUARTER = 4
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic                 wb_adr,
    input  eeprom_pkg::wb_data_t wb_dat_w,
    output eeprom_pkg::wb_data_t wb_dat_r,
    output logic                 wb_ack,
    output logic                 scl,
    output logic                 sda_oe,
    input  logic                 sda_in
);
    logic                 push;
    eeprom_pkg::ee_cmd_t  push_data;
    logic                 full;
    logic                 fifo_empty;
    logic                 pop;
    eeprom_pkg::ee_cmd_t  pop_data;
    logic                 busy;
    logic                 done;
    logic                 done_nack;
    logic                 done_read;
    eeprom_pkg::ee_data_t done_data;

    wb_cmd_port u_port (
        .CLK        (CLK),
        .RESET      (RESET),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .push       (push),
        .push_data  (push_data),
        .full       (full),
        .fifo_empty (fifo_empty),
        .busy       (busy),
        .done       (done),
        .done_nack  (done_nack),
        .done_read  (done_read),
        .done_data  (done_data)
    );

    cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (fifo_empty)
    );

    i2c_eeprom_master #(
        .SCL_QUARTER (SCL_QUARTER)
    ) u_master (
        .CLK       (CLK),
        .RESET     (RESET),
        .empty     (fifo_empty),
        .pop_data  (pop_data),
        .sda_in    (sda_in),
        .pop       (pop),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .busy      (busy),
        .done      (done),
        .done_nack (done_nack),
        .done_read (done_read),
        .done_data (done_data)
    );

endmodule

/* logic/eeprom_pkg.sv */
package eeprom_pkg;

    localparam int CMD_W = 20;

    typedef logic [10:0]      ee_addr_t;
    typedef logic [7:0]       ee_data_t;
    typedef logic [CMD_W-1:0] ee_cmd_t;   // {op, addr, data}
    typedef logic [31:0]      wb_data_t;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } ee_op_e;

    localparam logic [3:0] EE_DEVICE_CODE = 4'b1010;

    // command word fields
    localparam int CMD_OP_BIT   = 19;
    localparam int CMD_ADDR_LSB = 8;

    // status word bits, rd_data sits in 7:0
    localparam int STAT_BUSY  = 10;
    localparam int STAT_NACK  = 9;
    localparam int STAT_VALID = 8;

    typedef enum logic [3:0] {
        IDLE, START, CTRL_WR, ADDR, DATA_WR,
        RESTART, CTRL_RD, DATA_RD, STOP, DONE
    } master_state_e;

endpackage

/* logic/i2c_eeprom_master.sv */
`timescale 1ns/1ns
module i2c_eeprom_master #(
    parameter int SCL_QUARTER = 4
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 empty,
    input  eeprom_pkg::ee_cmd_t  pop_data,
    input  logic                 sda_in,
    output logic                 pop,
    output logic                 scl,
    output logic                 sda_oe,
    output logic                 busy,
    output logic                 done,
    output logic                 done_nack,
    output logic                 done_read,
    output eeprom_pkg::ee_data_t done_data
);
    localparam int QW = (SCL_QUARTER > 1) ? $clog2(SCL_QUARTER) : 1;

    eeprom_pkg::master_state_e state;
    logic [QW-1:0]             qcnt;
    logic [1:0]                quarter;
    logic                      tick;
    logic [8:0]                bit_sel;   // one-hot, bit 8 is the ack slot
    eeprom_pkg::ee_data_t      shreg;
    eeprom_pkg::ee_cmd_t       cmd;
    eeprom_pkg::ee_op_e        cmd_op;
    eeprom_pkg::ee_addr_t      cmd_addr;
    eeprom_pkg::ee_data_t      cmd_data;

    assign cmd_op   = eeprom_pkg::ee_op_e'(cmd[eeprom_pkg::CMD_OP_BIT]);
    assign cmd_addr = cmd[eeprom_pkg::CMD_ADDR_LSB +: $bits(eeprom_pkg::ee_addr_t)];
    assign cmd_data = cmd[7:0];

    assign tick      = (qcnt == QW'(SCL_QUARTER - 1));
    assign pop       = (state == eeprom_pkg::IDLE) && !empty;
    assign busy      = (state != eeprom_pkg::IDLE);
    assign done      = (state == eeprom_pkg::DONE);
    assign done_data = shreg;

    // quarter-period timing, restarted for every command
    always_ff @(posedge CLK)
    begin
        if (RESET || state == eeprom_pkg::IDLE)
        begin
            qcnt    <= '0;
            quarter <= 2'd0;
        end
        else if (tick)
        begin
            qcnt    <= '0;
            quarter <= quarter + 2'd1;
        end
        else
            qcnt <= qcnt + QW'(1);
    end

    always_ff @(posedge CLK)
    begin
        if (pop)
            cmd <= pop_data;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::IDLE;
            scl       <= 1'b1;
            sda_oe    <= 1'b0;
            done_nack <= 1'b0;
            done_read <= 1'b0;
            bit_sel   <= 9'd1;
        end
        else
        begin
            case (state)
                eeprom_pkg::IDLE:
                begin
                    if (!empty)
                    begin
                        done_nack <= 1'b0;
                        done_read <= (pop_data[eeprom_pkg::CMD_OP_BIT] == eeprom_pkg::OP_READ);
                        state     <= eeprom_pkg::START;
                    end
                end

                // start and repeated start look the same on the wire
                eeprom_pkg::START, eeprom_pkg::RESTART:
                begin
                    if (tick)
                    begin
                        case (quarter)
                            2'd0: sda_oe <= 1'b0;
                            2'd1: scl    <= 1'b1;
                            2'd2: sda_oe <= 1'b1;   // sda falls with scl high
                            default:
                            begin
                                scl     <= 1'b0;
                                bit_sel <= 9'd1;
                                shreg   <= {eeprom_pkg::EE_DEVICE_CODE, cmd_addr[10:8],
                                            state == eeprom_pkg::RESTART};
                                state   <= (state == eeprom_pkg::START) ?
                                           eeprom_pkg::CTRL_WR : eeprom_pkg::CTRL_RD;
                            end
                        endcase
                    end
                end

                eeprom_pkg::CTRL_WR, eeprom_pkg::ADDR,
                eeprom_pkg::DATA_WR, eeprom_pkg::CTRL_RD:
                begin
                    if (tick)
                    begin
                        case (quarter)
                            2'd0: sda_oe <= !bit_sel[8] && !shreg[7];   // release for ack
                            2'd1: scl    <= 1'b1;
                            2'd2:
                            begin
                                if (bit_sel[8] && sda_in)
                                    done_nack <= 1'b1;
                            end
                            default:
                            begin
                                scl     <= 1'b0;
                                shreg   <= {shreg[6:0], 1'b0};
                                bit_sel <= {bit_sel[7:0], bit_sel[8]};
                                if (bit_sel[8])
                                begin
                                    if (done_nack)
                                        state <= eeprom_pkg::STOP;
                                    else if (state == eeprom_pkg::CTRL_WR)
                                    begin
                                        shreg <= cmd_addr[7:0];
                                        state <= eeprom_pkg::ADDR;
                                    end
                                    else if (state == eeprom_pkg::ADDR)
                                    begin
                                        shreg <= cmd_data;
                                        state <= (cmd_op == eeprom_pkg::OP_WRITE) ?
                                                 eeprom_pkg::DATA_WR : eeprom_pkg::RESTART;
                                    end
                                    else if (state == eeprom_pkg::CTRL_RD)
                                        state <= eeprom_pkg::DATA_RD;
                                    else
                                        state <= eeprom_pkg::STOP;
                                end
                            end
                        endcase
                    end
                end

                eeprom_pkg::DATA_RD:
                begin
                    if (tick)
                    begin
                        case (quarter)
                            2'd0: sda_oe <= 1'b0;   // master nack on the last slot
                            2'd1: scl    <= 1'b1;
                            2'd2:
                            begin
                                if (!bit_sel[8])
                                    shreg <= {shreg[6:0], sda_in};
                            end
                            default:
                            begin
                                scl     <= 1'b0;
                                bit_sel <= {bit_sel[7:0], bit_sel[8]};
                                if (bit_sel[8])
                                    state <= eeprom_pkg::STOP;
                            end
                        endcase
                    end
                end

                eeprom_pkg::STOP:
                begin
                    if (tick)
                    begin
                        case (quarter)
                            2'd0: sda_oe <= 1'b1;
                            2'd1: scl    <= 1'b1;
                            2'd2: sda_oe <= 1'b0;   // sda rises with scl high
                            default: state <= eeprom_pkg::DONE;
                        endcase
                    end
                end

                eeprom_pkg::DONE: state <= eeprom_pkg::IDLE;

                default: state <= eeprom_pkg::IDLE;
            endcase
        end
    end

endmodule

/* logic/wb_cmd_port.sv */
`timescale 1ns/1ns
module wb_cmd_port (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic                 wb_adr,
    input  eeprom_pkg::wb_data_t wb_dat_w,
    output eeprom_pkg::wb_data_t wb_dat_r,
    output logic                 wb_ack,
    output logic                 push,
    output eeprom_pkg::ee_cmd_t  push_data,
    input  logic                 full,
    input  logic                 fifo_empty,
    input  logic                 busy,
    input  logic                 done,
    input  logic                 done_nack,
    input  logic                 done_read,
    input  eeprom_pkg::ee_data_t done_data
);
    logic                 req;
    logic                 cmd_wr;
    logic                 stat_rd;
    logic                 nack;
    logic                 rd_valid;
    eeprom_pkg::ee_data_t rd_data;
    eeprom_pkg::wb_data_t status;

    assign req     = wb_cyc && wb_stb && !wb_ack;   // no second hit in the ack cycle
    assign cmd_wr  = req && wb_we && (wb_adr == 1'b0);
    assign stat_rd = req && !wb_we && (wb_adr == 1'b1);

    assign push      = cmd_wr && !full;
    assign push_data = wb_dat_w[eeprom_pkg::CMD_W-1:0];

    always_comb
    begin
        status = '0;
        status[eeprom_pkg::STAT_BUSY]  = busy || !fifo_empty;
        status[eeprom_pkg::STAT_NACK]  = nack;
        status[eeprom_pkg::STAT_VALID] = rd_valid;
        status[7:0]                    = rd_data;
    end

    // full fifo stalls the ack until a word leaves
    always_ff @(posedge CLK)
    begin
        if (RESET)
            wb_ack <= 1'b0;
        else
            wb_ack <= req && !(cmd_wr && full);
    end

    always_ff @(posedge CLK)
    begin
        if (req && !wb_we)
            wb_dat_r <= stat_rd ? status : '0;
    end

    // a finishing command wins over the read clear
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            nack     <= 1'b0;
            rd_valid <= 1'b0;
        end
        else if (done)
        begin
            nack <= nack || done_nack;
            if (done_read && !done_nack)
                rd_valid <= 1'b1;
        end
        else if (stat_rd)
        begin
            nack     <= 1'b0;
            rd_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            rd_data <= '0;
        else if (done)
        begin
            if (done_read && !done_nack)
                rd_data <= done_data;
        end
        else if (stat_rd)
            rd_data <= '0;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_eeprom_ctrl \
    -f eeprom_ctrl_top.f \
    --Mdir obj_dir -o sim_eeprom

./obj_dir/sim_eeprom > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

/* tb/eeprom_ctrl_asserts.sv */
`timescale 1ns/1ns
module eeprom_ctrl_asserts (
    input logic                      CLK,
    input logic                      RESET,
    input eeprom_pkg::master_state_e state,
    input logic                      scl,
    input logic                      sda_oe,
    input logic                      done,
    input logic                      pop,
    input logic                      empty
);
    // data moves only with scl low, bus conditions excepted
    property sda_stable_high;
        @(posedge CLK) disable iff (RESET)
        (sda_oe != $past(sda_oe)) |-> (!$past(scl) ||
            $past(state) == eeprom_pkg::START ||
            $past(state) == eeprom_pkg::RESTART ||
            $past(state) == eeprom_pkg::STOP);
    endproperty

    assert property (sda_stable_high)
        else $error("sda_oe changed while scl was high");

    // single pulse, and the stop has left the bus free
    assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done && scl && !sda_oe)
        else $error("done lasted more than one cycle or left the bus held");

    assert property (@(posedge CLK) disable iff (RESET)
        pop |-> !empty && scl && !sda_oe)
        else $error("pop asserted on an empty fifo or a busy bus");

endmodule

bind i2c_eeprom_master eeprom_ctrl_asserts u_asserts (
    .CLK    (CLK),
    .RESET  (RESET),
    .state  (state),
    .scl    (scl),
    .sda_oe (sda_oe),
    .done   (done),
    .pop    (pop),
    .empty  (empty)
);

/* tb/eeprom_model.sv */
`timescale 1ns/1ns
module eeprom_model (
    input  logic scl,
    input  logic sda,
    output logic sda_release
);
    localparam int ST_IDLE = 0;
    localparam int ST_CTRL = 1;
    localparam int ST_ADDR = 2;
    localparam int ST_DATA = 3;
    localparam int ST_TX   = 4;

    logic [7:0] mem [1024];   // blocks 0 to 3 only
    int         state;
    logic [3:0] bitcnt;
    logic [7:0] sh;
    logic [7:0] txb;
    logic [7:0] lo;
    logic [2:0] blk;
    logic       rw;
    logic       prev_scl;
    logic       prev_sda;

    initial
    begin
        for (int i = 0; i < 1024; i++)
            mem[i] = 8'hFF;
        sda_release = 1'b1;
        state       = ST_IDLE;
        bitcnt      = 4'd0;
        prev_scl    = 1'b1;
        prev_sda    = 1'b1;
    end

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl === 1'b1 && prev_scl === 1'b1 && prev_sda === 1'b1 && sda === 1'b0)
        begin
            state       = ST_CTRL;   // start or repeated start
            bitcnt      = 4'd0;
            sda_release = 1'b1;
        end
        else if (scl === 1'b1 && prev_scl === 1'b1 && prev_sda === 1'b0 && sda === 1'b1)
        begin
            state       = ST_IDLE;   // stop
            sda_release = 1'b1;
        end
        else if (scl === 1'b1 && prev_scl === 1'b0 && state != ST_IDLE)
        begin
            if (bitcnt < 4'd8)
            begin
                if (state != ST_TX)
                    sh = {sh[6:0], sda};
                bitcnt = bitcnt + 4'd1;
            end
            else
                bitcnt = 4'd9;   // ack clock
        end
        else if (scl === 1'b0 && prev_scl === 1'b1 && state != ST_IDLE)
        begin
            if (bitcnt == 4'd8 && state != ST_TX)
            begin
                if (state == ST_CTRL)
                begin
                    if (sh[7:4] == 4'hA && !sh[3])
                    begin
                        blk         = sh[3:1];
                        rw          = sh[0];
                        sda_release = 1'b0;
                    end
                    else
                        state = ST_IDLE;   // no such block, stay silent
                end
                else if (state == ST_ADDR)
                begin
                    lo          = sh;
                    sda_release = 1'b0;
                end
                else
                begin
                    mem[{blk[1:0], lo}] = sh;
                    sda_release         = 1'b0;
                end
            end
            else if (bitcnt == 4'd9)
            begin
                sda_release = 1'b1;
                bitcnt      = 4'd0;
                if (state == ST_CTRL && rw)
                begin
                    state       = ST_TX;
                    txb         = mem[{blk[1:0], lo}];
                    sda_release = txb[7];
                end
                else if (state == ST_CTRL)
                    state = ST_ADDR;
                else if (state == ST_ADDR)
                    state = ST_DATA;
                else
                    state = ST_IDLE;
            end
            else if (state == ST_TX)
                sda_release = (bitcnt < 4'd8) ? txb[3'd7 - bitcnt[2:0]] : 1'b1;
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

/* tb/eeprom_vectors.txt */
# columns: W addr data | R addr | S expected_status, all hex
# status bits: 10 busy, 9 nack, 8 rd_valid, 7..0 rd_data
S 000
W 0A1 C3
R 0A1
S 1C3
W 2A5 5A
R 2A5
S 15A
R 123
S 1FF
W 010 11
W 011 22
W 012 33
W 013 44
W 014 55
W 015 66
R 010
S 111
R 011
S 122
R 012
S 133
R 013
S 144
R 014
S 155
R 015
S 166
W 400 77
S 200
S 000
R 7F0
S 200
S 000
W 055 3C
R 055
S 13C

/* tb/result_checker.sv */
`timescale 1ns/1ns
module result_checker (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wb_we,
    input  logic                 wb_adr,
    input  logic                 wb_ack,
    input  eeprom_pkg::wb_data_t wb_dat_r
);
    int                   fd;
    int                   checks;
    int                   errors;
    logic [10:0]          expected;
    logic                 found;
    eeprom_pkg::wb_data_t want;

    initial
    begin
        checks = 0;
        errors = 0;
        fd = $fopen("tb/eeprom_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("checker could not open the vectors file");
            errors = 1;
        end
    end

    // skip to the next S line
    task automatic next_expected(output logic [10:0] value, output logic ok);
        logic [7:0]      ch;
        logic [8*128:1]  rest;
        int              r;
        ok    = 1'b0;
        value = '0;
        while (!ok && fd != 0)
        begin
            r = $fscanf(fd, " %c", ch);
            if (r != 1)
                break;
            if (ch == "S")
            begin
                r  = $fscanf(fd, "%h", value);
                ok = 1'b1;
            end
            else
                r = $fgets(rest, fd);
        end
    endtask

    always @(posedge CLK)
    begin
        if (!RESET && wb_ack && !wb_we && wb_adr && !wb_dat_r[eeprom_pkg::STAT_BUSY])
        begin
            next_expected(expected, found);
            checks = checks + 1;
            want   = {21'd0, expected};
            if (!found)
            begin
                errors = errors + 1;
                $display("status read %0d at %0t ns has no expected value left", checks, $time);
            end
            else if (wb_dat_r !== want)
            begin
                errors = errors + 1;
                $display("[ERROR] %0t ns status test %0d expected %03h got %08h",
                         $time, checks, expected, wb_dat_r);
            end
            else
                $display("status test %0d ok, read %03h", checks, expected);
        end
    end

    task automatic report_counts();
        $display("checks %0d, errors %0d", checks, errors);
    endtask

endmodule

/* tb/tb_eeprom_ctrl.sv */
`timescale 1ns/1ns
module tb_eeprom_ctrl;
    localparam int    FIFO_DEPTH  = 4;
    localparam int    SCL_QUARTER = 4;
    localparam longint READ_NS    = longint'(10 * 36 * SCL_QUARTER * 100);   // a read, about 10 byte-times

    logic                 CLK;
    logic                 RESET;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic                 wb_adr;
    eeprom_pkg::wb_data_t wb_dat_w;
    eeprom_pkg::wb_data_t wb_dat_r;
    logic                 wb_ack;
    logic                 scl;
    logic                 sda_oe;
    logic                 sda_release;
    logic                 sda;
    int                   s_lines;

    assign sda = !sda_oe && sda_release;   // wired-AND bus

    eeprom_ctrl_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .SCL_QUARTER (SCL_QUARTER)
    ) UUT (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda)
    );

    eeprom_model u_model (.scl(scl), .sda(sda), .sda_release(sda_release));

    result_checker u_checker (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r)
    );

    initial
        CLK = 1'b0;
    always #50 CLK = !CLK;

    task automatic bus_write(input eeprom_pkg::wb_data_t value);
        @(negedge CLK);
        {wb_cyc, wb_stb, wb_we, wb_adr} = 4'b1110;
        wb_dat_w = value;
        do
            @(negedge CLK);
        while (!wb_ack);   // held through back-pressure
        {wb_cyc, wb_stb, wb_we} = 3'b000;
    endtask

    task automatic bus_read(output eeprom_pkg::wb_data_t value);
        @(negedge CLK);
        {wb_cyc, wb_stb, wb_we, wb_adr} = 4'b1101;
        do
            @(negedge CLK);
        while (!wb_ack);
        value = wb_dat_r;
        {wb_cyc, wb_stb} = 2'b00;
    endtask

    // watchdog sized from the vector count
    initial
    begin
        int             wfd;
        int             n;
        longint         limit;
        logic [8*128:1] line;
        n   = 0;
        wfd = $fopen("tb/eeprom_vectors.txt", "r");
        if (wfd != 0)
        begin
            while (!$feof(wfd))
                if ($fgets(line, wfd) != 0)
                    n = n + 1;
            $fclose(wfd);
        end
        limit = (longint'(n) + 1) * READ_NS * 4;
        #(limit);
        $display("timeout: the commands did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        int                   fd;
        int                   r;
        logic [7:0]           ch;
        logic [10:0]          addr;
        logic [7:0]           data;
        logic [10:0]          expected;
        logic [8*128:1]       rest;
        logic                 bad_line;
        eeprom_pkg::wb_data_t st;
        RESET    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 1'b0;
        wb_dat_w = '0;
        s_lines  = 0;
        bad_line = 1'b0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        fd = $fopen("tb/eeprom_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("could not open tb/eeprom_vectors.txt");
            bad_line = 1'b1;
        end
        while (fd != 0)
        begin
            r = $fscanf(fd, " %c", ch);
            if (r != 1)
                break;
            if (ch == "W")
            begin
                r = $fscanf(fd, "%h %h", addr, data);
                bus_write({12'd0, eeprom_pkg::OP_WRITE, addr, data});
            end
            else if (ch == "R")
            begin
                r = $fscanf(fd, "%h", addr);
                bus_write({12'd0, eeprom_pkg::OP_READ, addr, 8'h00});
            end
            else if (ch == "S")
            begin
                r = $fscanf(fd, "%h", expected);
                s_lines = s_lines + 1;
                do
                    bus_read(st);   // last read, busy clear, is the counted one
                while (st[eeprom_pkg::STAT_BUSY]);
                $display("line S %03h done", expected);
            end
            else if (ch == "#")
                r = $fgets(rest, fd);
            else
            begin
                $display("unknown line type in the vectors file");
                bad_line = 1'b1;
                r = $fgets(rest, fd);
            end
        end
        repeat (2) @(posedge CLK);
        u_checker.report_counts();
        if (!bad_line && u_checker.errors == 0 && u_checker.checks == s_lines && s_lines > 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
